// ==== hdl/lenet_pkg.sv ====
package lenet_pkg;

    ////////////////////
    // map geometry
    ////////////////////
    localparam int IMG_DIM  = 8;
    localparam int KER_DIM  = 3;
    localparam int CONV_DIM = IMG_DIM - KER_DIM + 1;
    localparam int POOL_DIM = CONV_DIM / 2;
    localparam int TAP_NUM  = KER_DIM * KER_DIM;  // tap index TAP_NUM selects the bias

    // row index widths
    localparam int IMG_AW  = $clog2(IMG_DIM);
    localparam int CONV_AW = $clog2(CONV_DIM);
    localparam int POOL_AW = $clog2(POOL_DIM);

    ////////////////////
    // number format
    ////////////////////
    localparam int PIX_W     = 16;
    localparam int FRAC_BITS = 8;   // Q8.8
    localparam int ACC_W     = 36;  // nine products plus bias, with headroom

    typedef logic signed [PIX_W-1:0] pixel_t;

    // pix[0] is the leftmost column
    typedef struct packed {
        pixel_t [IMG_DIM-1:0] pix;
    } img_row_t;

    typedef struct packed {
        pixel_t [CONV_DIM-1:0] pix;
    } conv_row_t;

    typedef struct packed {
        pixel_t [POOL_DIM-1:0] pix;
    } pool_row_t;

    typedef struct packed {
        logic [$clog2(TAP_NUM+1)-1:0] tap;
        pixel_t                       value;
    } ker_wr_t;

    typedef enum logic [1:0] {S_IDLE, S_CONV, S_POOL, S_DONE} layer_state_t;

endpackage

// ==== hdl/fm_ram.sv ====
`timescale 1ns/10ps

// row memory, one write port and one registered read port
module fm_ram #(
    parameter int  DEPTH = 8,
    parameter type ROW_T = logic
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_idx,
    input  ROW_T                     wr_row,
    input  logic [$clog2(DEPTH)-1:0] rd_idx,
    output ROW_T                     rd_row
);

    ROW_T mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_idx] <= wr_row;
    end

    always_ff @(posedge clk)
    begin
        rd_row <= mem[rd_idx];  // data one cycle after index
    end

endmodule

// ==== hdl/layer_sequencer.sv ====
`timescale 1ns/10ps

module layer_sequencer
    import lenet_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic conv_finish,
    input  logic pool_finish,
    output logic conv_en,
    output logic pool_en,
    output logic busy,
    output logic done
);

    layer_state_t state;
    layer_state_t state_nxt;

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE: if (start) state_nxt = S_CONV;  // start only seen while idle
            S_CONV: if (conv_finish) state_nxt = S_POOL;
            S_POOL: if (pool_finish) state_nxt = S_DONE;
            S_DONE: state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    // layer enables held as levels
    assign conv_en = (state == S_CONV);
    assign pool_en = (state == S_POOL);

    // done and busy drop together when S_DONE leaves
    assign done = (state == S_DONE);
    assign busy = (state != S_IDLE);

endmodule

// ==== hdl/conv_engine.sv ====
`timescale 1ns/10ps

module conv_engine
    import lenet_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               conv_en,
    input  logic               ker_wr_en,
    input  ker_wr_t            ker_wr,
    output logic [IMG_AW-1:0]  img_rd_idx,
    input  img_row_t           img_rd_row,
    output logic               conv_wr_en,
    output logic [CONV_AW-1:0] conv_wr_idx,
    output conv_row_t          conv_wr_row,
    output logic               conv_finish
);

    typedef enum logic [2:0] {C_IDLE, C_FETCH, C_MAC, C_WRITE, C_HOLD} conv_state_t;

    conv_state_t        state;
    logic [3:0]         cnt;      // fetch step, then tap index
    logic [CONV_AW-1:0] row_cnt;
    logic [1:0]         tap_row;
    logic [1:0]         tap_col;
    pixel_t             ker [TAP_NUM];
    pixel_t             bias;
    img_row_t           win [KER_DIM];  // three input rows under the kernel

    // kernel and bias registers, kept across runs
    always_ff @(posedge clk)
    begin
        if (ker_wr_en)
        begin
            if (ker_wr.tap == TAP_NUM)
                bias <= ker_wr.value;
            else if (ker_wr.tap < TAP_NUM)
                ker[ker_wr.tap] <= ker_wr.value;
        end
    end

    ////////////////////
    // row sequencing
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= C_IDLE;
            cnt     <= '0;
            row_cnt <= '0;
        end
        else
        begin
            case (state)
                C_IDLE:
                begin
                    cnt     <= '0;
                    row_cnt <= '0;
                    if (conv_en)
                        state <= C_FETCH;
                end
                C_FETCH:
                begin
                    if (cnt == 4'(KER_DIM))  // last row arrives on this step
                    begin
                        cnt   <= '0;
                        state <= C_MAC;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                C_MAC:
                begin
                    if (cnt == 4'(TAP_NUM - 1))
                    begin
                        cnt   <= '0;
                        state <= C_WRITE;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                C_WRITE:
                begin
                    if (row_cnt == CONV_AW'(CONV_DIM - 1))
                        state <= C_HOLD;
                    else
                    begin
                        row_cnt <= row_cnt + 1'b1;
                        state   <= C_FETCH;
                    end
                end
                C_HOLD: if (!conv_en) state <= C_IDLE;  // wait for a fresh enable
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == C_FETCH && cnt != 4'd0)
            win[2'(cnt - 1'b1)] <= img_rd_row;
    end

    assign img_rd_idx  = IMG_AW'(row_cnt + cnt);
    assign tap_row     = 2'(cnt / KER_DIM);
    assign tap_col     = 2'(cnt % KER_DIM);
    assign conv_wr_en  = (state == C_WRITE);
    assign conv_wr_idx = row_cnt;
    assign conv_finish = conv_wr_en && (row_cnt == CONV_AW'(CONV_DIM - 1));

    ////////////////////
    // mac lanes
    ////////////////////
    for (genvar l = 0; l < CONV_DIM; l++)
    begin : g_lane
        pixel_t                    tap_pix;
        pixel_t                    sat;
        logic signed [2*PIX_W-1:0] prod;
        logic signed [ACC_W-1:0]   acc;
        logic signed [ACC_W-1:0]   scaled;

        assign tap_pix = win[tap_row].pix[l + tap_col];
        assign prod    = tap_pix * ker[cnt];
        assign scaled  = acc >>> FRAC_BITS;  // back to Q8.8

        always_ff @(posedge clk)
        begin
            if (state == C_FETCH)  // bias moved into product format
                acc <= {{(ACC_W-PIX_W-FRAC_BITS){bias[PIX_W-1]}}, bias, {FRAC_BITS{1'b0}}};
            else if (state == C_MAC)
                acc <= acc + ACC_W'(prod);
        end

        always_comb
        begin
            if (scaled > 32767)
                sat = 16'sh7fff;
            else if (scaled < -32768)
                sat = 16'sh8000;
            else
                sat = pixel_t'(scaled);
        end

        assign conv_wr_row.pix[l] = sat;
    end

endmodule

// ==== hdl/pool_engine.sv ====
`timescale 1ns/10ps

module pool_engine
    import lenet_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               pool_en,
    output logic [CONV_AW-1:0] conv_rd_idx,
    input  conv_row_t          conv_rd_row,
    output logic               pool_wr_en,
    output logic [POOL_AW-1:0] pool_wr_idx,
    output pool_row_t          pool_wr_row,
    output logic               pool_finish
);

    typedef enum logic [1:0] {P_IDLE, P_READ, P_WRITE, P_HOLD} pool_state_t;

    pool_state_t        state;
    logic [1:0]         cnt;
    logic [POOL_AW-1:0] row_cnt;
    conv_row_t          top_row;
    conv_row_t          bot_row;

    function automatic pixel_t max2(input pixel_t a, input pixel_t b);
        return (a > b) ? a : b;  // signed compare
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= P_IDLE;
            cnt     <= '0;
            row_cnt <= '0;
        end
        else
        begin
            case (state)
                P_IDLE:
                begin
                    cnt     <= '0;
                    row_cnt <= '0;
                    if (pool_en)
                        state <= P_READ;
                end
                P_READ:
                begin
                    if (cnt == 2'd2)
                    begin
                        cnt   <= '0;
                        state <= P_WRITE;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                P_WRITE:
                begin
                    if (row_cnt == POOL_AW'(POOL_DIM - 1))
                        state <= P_HOLD;
                    else
                    begin
                        row_cnt <= row_cnt + 1'b1;
                        state   <= P_READ;
                    end
                end
                P_HOLD: if (!pool_en) state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

    // row pair lands one cycle after each index
    always_ff @(posedge clk)
    begin
        if (state == P_READ && cnt == 2'd1)
            top_row <= conv_rd_row;
        if (state == P_READ && cnt == 2'd2)
            bot_row <= conv_rd_row;
    end

    assign conv_rd_idx = CONV_AW'(2 * row_cnt + cnt);
    assign pool_wr_en  = (state == P_WRITE);
    assign pool_wr_idx = row_cnt;
    assign pool_finish = pool_wr_en && (row_cnt == POOL_AW'(POOL_DIM - 1));

    for (genvar c = 0; c < POOL_DIM; c++)
    begin : g_max
        assign pool_wr_row.pix[c] = max2(max2(top_row.pix[2*c], top_row.pix[2*c+1]),
                                         max2(bot_row.pix[2*c], bot_row.pix[2*c+1]));
    end

endmodule

// ==== hdl/lenet_top.sv ====
`timescale 1ns/10ps

module lenet_top
    import lenet_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               load_en,
    input  logic [IMG_AW-1:0]  load_row_idx,
    input  img_row_t           load_row,
    input  logic               ker_wr_en,
    input  ker_wr_t            ker_wr,
    input  logic [POOL_AW-1:0] rd_row_idx,
    output pool_row_t          rd_row,
    output logic               busy,
    output logic               done
);

    logic               conv_en;
    logic               pool_en;
    logic               conv_finish;
    logic               pool_finish;

    // input map read by the convolution
    logic [IMG_AW-1:0]  img_rd_idx;
    img_row_t           img_rd_row;

    // convolution map, written by conv and read by pool
    logic               conv_wr_en;
    logic [CONV_AW-1:0] conv_wr_idx;
    conv_row_t          conv_wr_row;
    logic [CONV_AW-1:0] conv_rd_idx;
    conv_row_t          conv_rd_row;

    // pooled map
    logic               pool_wr_en;
    logic [POOL_AW-1:0] pool_wr_idx;
    pool_row_t          pool_wr_row;

    layer_sequencer u_layer_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .conv_finish (conv_finish),
        .pool_finish (pool_finish),
        .conv_en     (conv_en),
        .pool_en     (pool_en),
        .busy        (busy),
        .done        (done)
    );

    fm_ram #(.DEPTH(IMG_DIM), .ROW_T(img_row_t)) img_ram (
        .clk    (clk),
        .wr_en  (load_en),
        .wr_idx (load_row_idx),
        .wr_row (load_row),
        .rd_idx (img_rd_idx),
        .rd_row (img_rd_row)
    );

    fm_ram #(.DEPTH(CONV_DIM), .ROW_T(conv_row_t)) conv_ram (
        .clk    (clk),
        .wr_en  (conv_wr_en),
        .wr_idx (conv_wr_idx),
        .wr_row (conv_wr_row),
        .rd_idx (conv_rd_idx),
        .rd_row (conv_rd_row)
    );

    fm_ram #(.DEPTH(POOL_DIM), .ROW_T(pool_row_t)) pool_ram (
        .clk    (clk),
        .wr_en  (pool_wr_en),
        .wr_idx (pool_wr_idx),
        .wr_row (pool_wr_row),
        .rd_idx (rd_row_idx),  // readout port
        .rd_row (rd_row)
    );

    conv_engine u_conv_engine (
        .clk         (clk),
        .rst         (rst),
        .conv_en     (conv_en),
        .ker_wr_en   (ker_wr_en),
        .ker_wr      (ker_wr),
        .img_rd_idx  (img_rd_idx),
        .img_rd_row  (img_rd_row),
        .conv_wr_en  (conv_wr_en),
        .conv_wr_idx (conv_wr_idx),
        .conv_wr_row (conv_wr_row),
        .conv_finish (conv_finish)
    );

    pool_engine u_pool_engine (
        .clk         (clk),
        .rst         (rst),
        .pool_en     (pool_en),
        .conv_rd_idx (conv_rd_idx),
        .conv_rd_row (conv_rd_row),
        .pool_wr_en  (pool_wr_en),
        .pool_wr_idx (pool_wr_idx),
        .pool_wr_row (pool_wr_row),
        .pool_finish (pool_finish)
    );

endmodule

// ==== verification/lenet_assert.sv ====
`timescale 1ns/10ps

module lenet_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done,
    input logic conv_en,
    input logic pool_en
);

    // only one layer engine enabled at a time
    a_en_exclusive: assert property (@(posedge clk) disable iff (rst) !(conv_en && pool_en))
        else $error("conv_en and pool_en high in the same cycle");

    a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    // busy drops together with done
    a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy ##1 !busy)
        else $error("busy did not fall together with done");

    a_start_busy: assert property (@(posedge clk) disable iff (rst) (start && !busy) |=> busy)
        else $error("busy did not rise one cycle after an accepted start");

endmodule

bind lenet_top lenet_assert lenet_assert_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .conv_en (conv_en),
    .pool_en (pool_en)
);

// ==== verification/lenet_tb.sv ====
`timescale 1ns/10ps

module lenet_tb
    import lenet_pkg::*;
();

    logic               clk;
    logic               rst;
    logic               start;
    logic               load_en;
    logic [IMG_AW-1:0]  load_row_idx;
    img_row_t           load_row;
    logic               ker_wr_en;
    ker_wr_t            ker_wr;
    logic [POOL_AW-1:0] rd_row_idx;
    pool_row_t          rd_row;
    logic               busy;
    logic               done;

    // model state held as plain integers
    int img_m [IMG_DIM][IMG_DIM];
    int ker_m [TAP_NUM];
    int bias_m;
    int exp_m [POOL_DIM][POOL_DIM];

    lenet_top lenet_top_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .load_en      (load_en),
        .load_row_idx (load_row_idx),
        .load_row     (load_row),
        .ker_wr_en    (ker_wr_en),
        .ker_wr       (ker_wr),
        .rd_row_idx   (rd_row_idx),
        .rd_row       (rd_row),
        .busy         (busy),
        .done         (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic step();
        @(posedge clk);
        #1;  // drive and sample point
    endtask

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] want);
        assert (got === want)
        else
            stop_with_fail($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, want));
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    task automatic randomize_image(input int lo, input int hi);
        for (int r = 0; r < IMG_DIM; r++)
            for (int c = 0; c < IMG_DIM; c++)
                img_m[r][c] = rand_range(lo, hi);
    endtask

    task automatic randomize_kernel();
        for (int t = 0; t < TAP_NUM; t++)
            ker_m[t] = rand_range(-128, 127);  // within +-0.5
        bias_m = rand_range(-512, 511);
    endtask

    task automatic load_image();
        for (int r = 0; r < IMG_DIM; r++)
        begin
            load_en      = 1'b1;
            load_row_idx = IMG_AW'(r);
            for (int c = 0; c < IMG_DIM; c++)
                load_row.pix[c] = pixel_t'(img_m[r][c]);
            step();
        end
        load_en = 1'b0;
    endtask

    task automatic load_kernel();
        for (int t = 0; t <= TAP_NUM; t++)
        begin
            ker_wr_en  = 1'b1;
            ker_wr.tap = 4'(t);
            if (t == TAP_NUM)
                ker_wr.value = pixel_t'(bias_m);  // bias slot
            else
                ker_wr.value = pixel_t'(ker_m[t]);
            step();
        end
        ker_wr_en = 1'b0;
    endtask

    // conv and Q8.8 requantise with saturation followed by 2x2 max
    task automatic compute_expected();
        int     conv_m [CONV_DIM][CONV_DIM];
        longint acc;
        longint q;
        int     m;
        for (int i = 0; i < CONV_DIM; i++)
            for (int j = 0; j < CONV_DIM; j++)
            begin
                acc = longint'(bias_m) * (longint'(1) << FRAC_BITS);
                for (int r = 0; r < KER_DIM; r++)
                    for (int c = 0; c < KER_DIM; c++)
                        acc += longint'(img_m[i+r][j+c]) * ker_m[r*KER_DIM+c];
                q = acc >>> FRAC_BITS;  // floor shift
                if (q > 32767)
                    q = 32767;
                else if (q < -32768)
                    q = -32768;
                conv_m[i][j] = int'(q);
            end
        for (int pr = 0; pr < POOL_DIM; pr++)
            for (int pc = 0; pc < POOL_DIM; pc++)
            begin
                m = conv_m[2*pr][2*pc];
                for (int d = 1; d < 4; d++)
                    if (conv_m[2*pr + d/2][2*pc + d%2] > m)
                        m = conv_m[2*pr + d/2][2*pc + d%2];
                exp_m[pr][pc] = m;
            end
    endtask

    // start pulse and wait for done with an optional extra start while busy
    task automatic run_layers(input bit poke_while_busy);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        start  = 1'b1;
        step();
        start = 1'b0;
        check_hex("busy", 16'(busy), 16'h1);
        while (!seen && cycles < 200)
        begin
            start = poke_while_busy && (cycles == 10);
            step();
            cycles++;
            if (done)
                seen = 1'b1;
        end
        start = 1'b0;
        if (!seen)
            stop_with_fail("timeout: done did not arrive within 200 cycles");
        step();
        check_hex("done", 16'(done), 16'h0);
        check_hex("busy", 16'(busy), 16'h0);
    endtask

    task automatic check_readout();
        for (int r = 0; r < POOL_DIM; r++)
        begin
            rd_row_idx = POOL_AW'(r);
            step();  // registered read
            for (int c = 0; c < POOL_DIM; c++)
                check_hex($sformatf("rd_row.pix[%0d] at row %0d", c, r),
                          rd_row.pix[c], 16'(exp_m[r][c]));
        end
    endtask

    task automatic expect_idle(input int n);
        for (int i = 0; i < n; i++)
        begin
            step();
            check_hex("done", 16'(done), 16'h0);
            check_hex("busy", 16'(busy), 16'h0);
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic first_run_after_reset();
        check_hex("busy", 16'(busy), 16'h0);
        check_hex("done", 16'(done), 16'h0);
        for (int t = 0; t < TAP_NUM; t++)
            ker_m[t] = 0;
        bias_m = 0;
        randomize_image(-1024, 1023);
        load_kernel();
        load_image();
        compute_expected();
        run_layers(1'b0);
        check_readout();
    endtask

    task automatic identity_kernel_run();
        int m;
        for (int t = 0; t < TAP_NUM; t++)
            ker_m[t] = 0;
        ker_m[4] = 256;  // centre tap 1.0
        bias_m   = 0;
        randomize_image(-32768, 32767);
        // maxima of the interior 6x6 taken straight from the image
        for (int pr = 0; pr < POOL_DIM; pr++)
            for (int pc = 0; pc < POOL_DIM; pc++)
            begin
                m = img_m[2*pr+1][2*pc+1];
                for (int d = 1; d < 4; d++)
                    if (img_m[2*pr+1 + d/2][2*pc+1 + d%2] > m)
                        m = img_m[2*pr+1 + d/2][2*pc+1 + d%2];
                exp_m[pr][pc] = m;
            end
        load_kernel();
        load_image();
        run_layers(1'b0);
        check_readout();
    endtask

    task automatic random_kernel_run();
        randomize_kernel();
        randomize_image(-1024, 1023);
        load_kernel();
        load_image();
        compute_expected();
        run_layers(1'b0);
        check_readout();
    endtask

    task automatic saturation_run();
        for (int t = 0; t < TAP_NUM; t++)
            ker_m[t] = (t < 2*KER_DIM) ? 16384 : -16384;  // +-64.0 with bottom row negative
        bias_m = 0;
        // large positive upper half over a large negative lower half
        for (int r = 0; r < IMG_DIM; r++)
            for (int c = 0; c < IMG_DIM; c++)
                img_m[r][c] = (r < IMG_DIM/2) ? 28672 : -28672;
        compute_expected();
        for (int c = 0; c < POOL_DIM; c++)
        begin
            check_hex("model row 0", 16'(exp_m[0][c]), 16'h7fff);
            check_hex("model row 1", 16'(exp_m[1][c]), 16'h7fff);
            check_hex("model row 2", 16'(exp_m[2][c]), 16'h8000);
        end
        load_kernel();
        load_image();
        run_layers(1'b0);
        check_readout();
    endtask

    task automatic restart_and_rerun();
        randomize_kernel();
        randomize_image(-1024, 1023);
        load_kernel();
        load_image();
        compute_expected();
        run_layers(1'b1);  // extra start mid-run
        check_readout();
        expect_idle(150);  // no second done
        randomize_image(-1024, 1023);
        load_image();  // kernel kept from before
        compute_expected();
        run_layers(1'b0);
        check_readout();
        expect_idle(20);
        check_readout();
    endtask

    initial
    begin
        void'($urandom(32'haa4e));
        rst          = 1'b1;
        start        = 1'b0;
        load_en      = 1'b0;
        load_row_idx = '0;
        load_row     = '0;
        ker_wr_en    = 1'b0;
        ker_wr       = '0;
        rd_row_idx   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        step();

        first_run_after_reset();
        identity_kernel_run();
        random_kernel_run();
        saturation_run();
        restart_and_rerun();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/lenet_pkg.sv
hdl/fm_ram.sv
hdl/layer_sequencer.sv
hdl/conv_engine.sv
hdl/pool_engine.sv
hdl/lenet_top.sv
verification/lenet_assert.sv
verification/lenet_tb.sv

// ==== Bender.yml ====
package:
  name: lenet_layer

sources:
  # design, package first
  - files:
      - hdl/lenet_pkg.sv
      - hdl/fm_ram.sv
      - hdl/layer_sequencer.sv
      - hdl/conv_engine.sv
      - hdl/pool_engine.sv
      - hdl/lenet_top.sv
  # testbench and bound assertions
  - target: test
    files:
      - verification/lenet_assert.sv
      - verification/lenet_tb.sv
